// ==== filelist.f ====
verilog/csr_pkg.sv
verilog/csr_addr_decode.sv
verilog/csr_trap_unit.sv
verilog/csr_machine_regs.sv
verilog/csr_result.sv
verilog/csr_top.sv
testbench/csr_assertions.sv
testbench/csr_tb.sv

// ==== testbench/csr_tb.sv ====
// ##########################################################################
// Testbench for the machine CSR unit: reads, writes, traps, mret and
// vectored interrupts, checked by concurrent assertions
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module csr_tb;

  localparam int max_cycles = 2000;

  logic               clock;
  logic               reset;
  logic               wr_en;
  csr_pkg::csr_addr_t addr;
  csr_pkg::xlen_t     wr_data;
  logic               mret;
  logic               external_interrupt;
  logic               mem_msip;
  csr_pkg::timer_t    mem_mtime;
  csr_pkg::timer_t    mem_mtimecmp;
  csr_pkg::xlen_t     pc;
  csr_pkg::instr_t    instruction;
  logic               illegal_instruction;
  logic               ecall;
  csr_pkg::xlen_t     rd_data;
  logic               addr_exception;
  csr_pkg::xlen_t     mepc;
  csr_pkg::xlen_t     trap_addr;
  logic               trap;
  csr_pkg::priv_e     privilege_mode;

  // Expected values and check enables, driven with the stimulus
  logic           chk_rd;
  logic           chk_trap;
  logic           chk_priv;
  csr_pkg::xlen_t exp_rd;
  logic           exp_aexc;
  csr_pkg::xlen_t exp_trap_addr;
  csr_pkg::priv_e exp_priv;
  int             errors;
  int             checks;
  int             cycles;
  integer         seed;
  csr_pkg::xlen_t data;
  csr_pkg::xlen_t cause_exp;

  csr_top u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  read_value: assert property (@(posedge clock) disable iff (reset)
    chk_rd |-> (rd_data == exp_rd && addr_exception == exp_aexc)
  ) else begin
    errors++;
    $display("error at %0t: read of %h gave %h exc %b, expected %h exc %b", $time,
             $sampled(addr), $sampled(rd_data), $sampled(addr_exception), exp_rd, exp_aexc);
  end

  mepc_port: assert property (@(posedge clock) disable iff (reset)
    (chk_rd && addr == csr_pkg::addr_mepc) |-> mepc == exp_rd
  ) else begin
    errors++;
    $display("error at %0t: mepc port %h, expected %h", $time, $sampled(mepc), exp_rd);
  end

  // A trap fires exactly in the cycles the stimulus expects one
  trap_when_expected: assert property (@(posedge clock) disable iff (reset)
    trap == chk_trap
  ) else begin
    errors++;
    $display("error at %0t: trap is %b, expected %b", $time, $sampled(trap), chk_trap);
  end

  trap_target: assert property (@(posedge clock) disable iff (reset)
    chk_trap |-> trap_addr == exp_trap_addr
  ) else begin
    errors++;
    $display("error at %0t: trap_addr %h, expected %h", $time,
             $sampled(trap_addr), exp_trap_addr);
  end

  priv_value: assert property (@(posedge clock) disable iff (reset)
    chk_priv |-> privilege_mode == exp_priv
  ) else begin
    errors++;
    $display("error at %0t: privilege %0d, expected %0d", $time,
             $sampled(privilege_mode), exp_priv);
  end

  trap_enters_machine: assert property (@(posedge clock) disable iff (reset)
    trap |=> privilege_mode == csr_pkg::priv_machine
  ) else begin
    errors++;
    $display("error at %0t: privilege not machine after trap", $time);
  end

  // mcause accepts interrupts 3, 7, 11 and exceptions 2, 8, 11
  function automatic logic cause_is_supported(input csr_pkg::xlen_t value);
    logic [30:0] code;
    code = value[30:0];
    if (value[31]) begin
      cause_is_supported = (code == 3) || (code == 7) || (code == 11);
    end else begin
      cause_is_supported = (code == 2) || (code == 8) || (code == 11);
    end
  endfunction

  task automatic write_csr(input csr_pkg::csr_addr_t a, input csr_pkg::xlen_t d);
    wr_en   = 1'b1;
    addr    = a;
    wr_data = d;
    @(negedge clock);
    wr_en = 1'b0;
  endtask

  task automatic check_read(input csr_pkg::csr_addr_t a, input csr_pkg::xlen_t e,
                            input logic exc);
    addr     = a;
    exp_rd   = e;
    exp_aexc = exc;
    chk_rd   = 1'b1;
    checks++;
    @(negedge clock);
    chk_rd = 1'b0;
  endtask

  task automatic check_priv(input csr_pkg::priv_e p);
    exp_priv = p;
    chk_priv = 1'b1;
    checks++;
    @(negedge clock);
    chk_priv = 1'b0;
  endtask

  task automatic pulse_mret();
    mret = 1'b1;
    @(negedge clock);
    mret = 1'b0;
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    wr_en = 1'b0;
    addr = '0;
    wr_data = '0;
    mret = 1'b0;
    external_interrupt = 1'b0;
    mem_msip = 1'b0;
    mem_mtime = 64'd0;
    mem_mtimecmp = '1;
    pc = '0;
    instruction = '0;
    illegal_instruction = 1'b0;
    ecall = 1'b0;
    chk_rd = 1'b0;
    chk_trap = 1'b0;
    chk_priv = 1'b0;
    exp_rd = '0;
    exp_aexc = 1'b0;
    exp_trap_addr = '0;
    exp_priv = csr_pkg::priv_machine;
    errors = 0;
    checks = 0;
    seed = 90529;
    cause_exp = '0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // Reset state and the RV32 misa with I and U
    check_priv(csr_pkg::priv_machine);
    check_read(csr_pkg::addr_misa, (32'd1 << 30) | (32'd1 << 20) | (32'd1 << 8), 1'b0);
    check_read(12'h000, '0, 1'b1);
    check_read(12'h345, '0, 1'b1);
    check_read(12'hfff, '0, 1'b1);
    // All three pending sources at once
    external_interrupt = 1'b1;
    mem_msip = 1'b1;
    mem_mtimecmp = 64'd0;
    check_read(csr_pkg::addr_mip, 32'h0000_0888, 1'b0);
    external_interrupt = 1'b0;
    mem_msip = 1'b0;
    mem_mtimecmp = '1;

    // Random write and read back
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      write_csr(csr_pkg::addr_mscratch, data);
      check_read(csr_pkg::addr_mscratch, data, 1'b0);
      data = $random(seed);
      write_csr(csr_pkg::addr_mepc, data);
      check_read(csr_pkg::addr_mepc, data & ~32'h3, 1'b0);
      data = $random(seed);
      write_csr(csr_pkg::addr_mtvec, data);
      check_read(csr_pkg::addr_mtvec, data & ~32'h2, 1'b0);
      data = $random(seed);
      if (cause_is_supported(data)) begin
        cause_exp = data;
      end
      write_csr(csr_pkg::addr_mcause, data);
      check_read(csr_pkg::addr_mcause, cause_exp, 1'b0);
    end
    write_csr(csr_pkg::addr_mcause, 32'h8000_0003);
    check_read(csr_pkg::addr_mcause, 32'h8000_0003, 1'b0);
    write_csr(csr_pkg::addr_mstatus, 32'h0000_1800);
    check_read(csr_pkg::addr_mstatus, 32'h0000_1800, 1'b0);
    write_csr(csr_pkg::addr_mstatus, 32'h0000_0800);
    check_read(csr_pkg::addr_mstatus, 32'h0000_1800, 1'b0);

    // ecall in machine mode with a colliding mscratch write
    write_csr(csr_pkg::addr_mtvec, 32'h0000_1000);
    write_csr(csr_pkg::addr_mstatus, 32'h0000_1808);
    write_csr(csr_pkg::addr_mscratch, 32'h1234_5678);
    ecall = 1'b1;
    pc = 32'h0000_2000;
    wr_en = 1'b1;
    addr = csr_pkg::addr_mscratch;
    wr_data = 32'hdead_beef;
    exp_trap_addr = 32'h0000_1000;
    chk_trap = 1'b1;
    checks++;
    @(negedge clock);
    ecall = 1'b0;
    wr_en = 1'b0;
    chk_trap = 1'b0;
    check_read(csr_pkg::addr_mepc, 32'h0000_2000, 1'b0);
    check_read(csr_pkg::addr_mcause, 32'd11, 1'b0);
    check_read(csr_pkg::addr_mstatus, 32'h0000_1880, 1'b0);
    check_read(csr_pkg::addr_mscratch, 32'h1234_5678, 1'b0);

    // mret to user followed by an illegal instruction
    write_csr(csr_pkg::addr_mstatus, 32'h0000_0080);
    pulse_mret();
    check_priv(csr_pkg::priv_user);
    check_read(csr_pkg::addr_mstatus, 32'h0000_0088, 1'b0);
    illegal_instruction = 1'b1;
    instruction = 32'hc0de_1057;
    pc = 32'h0000_3004;
    chk_trap = 1'b1;
    checks++;
    @(negedge clock);
    illegal_instruction = 1'b0;
    chk_trap = 1'b0;
    check_priv(csr_pkg::priv_machine);
    check_read(csr_pkg::addr_mcause, 32'd2, 1'b0);
    check_read(csr_pkg::addr_mtval, 32'hc0de_1057, 1'b0);
    check_read(csr_pkg::addr_mepc, 32'h0000_3004, 1'b0);
    check_read(csr_pkg::addr_mstatus, 32'h0000_0080, 1'b0);

    // Vectored mode with external and timer raised together from user mode
    write_csr(csr_pkg::addr_mie, 32'hffff_ffff);
    check_read(csr_pkg::addr_mie, 32'h0000_0888, 1'b0);
    write_csr(csr_pkg::addr_mtvec, 32'h0000_1001);
    write_csr(csr_pkg::addr_mstatus, 32'h0000_0000);
    pulse_mret();
    check_priv(csr_pkg::priv_user);
    external_interrupt = 1'b1;
    mem_mtime = 64'd100;
    mem_mtimecmp = 64'd50;
    exp_trap_addr = 32'h0000_1000 + 4 * 11;
    chk_trap = 1'b1;
    checks++;
    @(negedge clock);
    external_interrupt = 1'b0;
    mem_mtimecmp = '1;
    chk_trap = 1'b0;
    check_priv(csr_pkg::priv_machine);
    check_read(csr_pkg::addr_mcause, 32'h8000_000b, 1'b0);
    pulse_mret();
    check_priv(csr_pkg::priv_user);
    mem_mtimecmp = 64'd50;
    exp_trap_addr = 32'h0000_1000 + 4 * 7;
    chk_trap = 1'b1;
    checks++;
    @(negedge clock);
    mem_mtimecmp = '1;
    chk_trap = 1'b0;
    check_read(csr_pkg::addr_mcause, 32'h8000_0007, 1'b0);

    // Software interrupt alone from user mode
    pulse_mret();
    mem_msip = 1'b1;
    exp_trap_addr = 32'h0000_1000 + 4 * 3;
    chk_trap = 1'b1;
    checks++;
    @(negedge clock);
    mem_msip = 1'b0;
    chk_trap = 1'b0;
    check_read(csr_pkg::addr_mcause, 32'h8000_0003, 1'b0);

    repeat (2) @(negedge clock);
    $display("checks: %0d, testbench errors: %0d, bound assertion errors: %0d",
             checks, errors, u_dut.u_assertions.failures);
    if (errors == 0 && u_dut.u_assertions.failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/csr_assertions.sv ====
// ##########################################################################
// Bound checks for the CSR unit: trap target alignment, reset privilege
// and write suppression on trap entry
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module csr_assertions (
  input logic               clock,
  input logic               reset,
  input logic               trap,
  input csr_pkg::xlen_t     trap_addr,
  input csr_pkg::priv_e     privilege_mode,
  input logic               wr_en,
  input csr_pkg::csr_addr_t addr,
  input csr_pkg::xlen_t     mscratch
);

  int unsigned failures = 0;

  // Trap vectors always land on a word boundary
  trap_addr_aligned: assert property (
    @(posedge clock) disable iff (reset) trap_addr[1:0] == 2'b00
  ) else begin
    failures++;
    $error("trap target address is not word aligned");
  end

  reset_priv_machine: assert property (
    @(posedge clock) reset |-> privilege_mode == csr_pkg::priv_machine
  ) else begin
    failures++;
    $error("privilege is not machine during reset");
  end

  // Trap entry wins over a CSR write in the same cycle
  trap_blocks_write: assert property (
    @(posedge clock) disable iff (reset)
      (trap && wr_en && addr == csr_pkg::addr_mscratch) |=> mscratch == $past(mscratch)
  ) else begin
    failures++;
    $error("mscratch changed by a write issued in a trap cycle");
  end

endmodule

bind csr_top csr_assertions u_assertions (
  .clock          (clock),
  .reset          (reset),
  .trap           (trap),
  .trap_addr      (trap_addr),
  .privilege_mode (privilege_mode),
  .wr_en          (wr_en),
  .addr           (addr),
  .mscratch       (state.mscratch)
);

`default_nettype wire

// ==== verilog/csr_top.sv ====
// ##########################################################################
// Machine-mode CSR unit top level for an RV32 M/U core
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module csr_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               wr_en,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     wr_data,
  input  logic               mret,
  input  logic               external_interrupt,
  input  logic               mem_msip,
  input  csr_pkg::timer_t    mem_mtime,
  input  csr_pkg::timer_t    mem_mtimecmp,
  input  csr_pkg::xlen_t     pc,
  input  csr_pkg::instr_t    instruction,
  input  logic               illegal_instruction,
  input  logic               ecall,
  output csr_pkg::xlen_t     rd_data,
  output logic               addr_exception,
  output csr_pkg::xlen_t     mepc,
  output csr_pkg::xlen_t     trap_addr,
  output logic               trap,
  output csr_pkg::priv_e     privilege_mode
);

  csr_pkg::csr_sel_t   sel;
  csr_pkg::csr_write_t wr;
  csr_pkg::csr_state_t state;
  csr_pkg::trap_t      trap_info;
  csr_pkg::xlen_t      mip;
  logic                mret_commit;

  csr_addr_decode u_decode (
    .addr           (addr),
    .wr_en          (wr_en),
    .wr_data        (wr_data),
    .mret           (mret),
    .trap           (trap_info.trap),
    .sel            (sel),
    .wr             (wr),
    .mret_commit    (mret_commit),
    .addr_exception (addr_exception)
  );

  csr_trap_unit u_trap (
    .state               (state),
    .mip                 (mip),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .trap_info           (trap_info)
  );

  csr_machine_regs u_regs (
    .clock              (clock),
    .reset              (reset),
    .wr                 (wr),
    .mret_commit        (mret_commit),
    .trap_info          (trap_info),
    .pc                 (pc),
    .instruction        (instruction),
    .external_interrupt (external_interrupt),
    .mem_msip           (mem_msip),
    .mem_mtime          (mem_mtime),
    .mem_mtimecmp       (mem_mtimecmp),
    .state              (state),
    .mip                (mip)
  );

  csr_result u_result (
    .sel       (sel),
    .state     (state),
    .mip       (mip),
    .trap_info (trap_info),
    .rd_data   (rd_data),
    .trap_addr (trap_addr)
  );

  assign mepc           = state.mepc;
  assign trap           = trap_info.trap;
  assign privilege_mode = state.priv;

endmodule

`default_nettype wire

// ==== verilog/csr_result.sv ====
// ##########################################################################
// CSR read data mux and trap target address
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module csr_result (
  input  csr_pkg::csr_sel_t   sel,
  input  csr_pkg::csr_state_t state,
  input  csr_pkg::xlen_t      mip,
  input  csr_pkg::trap_t      trap_info,
  output csr_pkg::xlen_t      rd_data,
  output csr_pkg::xlen_t      trap_addr
);

  csr_pkg::xlen_t mstatus_word;
  csr_pkg::xlen_t mie_word;
  csr_pkg::xlen_t mtvec_word;
  csr_pkg::xlen_t base_addr;
  csr_pkg::xlen_t vector_offset;

  always_comb begin
    mstatus_word                                = '0;
    mstatus_word[csr_pkg::mstatus_mie]          = state.status_mie;
    mstatus_word[csr_pkg::mstatus_mpie]         = state.status_mpie;
    mstatus_word[csr_pkg::mstatus_mpp +: 2]     = state.status_mpp;

    mie_word                   = '0;
    mie_word[csr_pkg::irq_msi] = state.msie;
    mie_word[csr_pkg::irq_mti] = state.mtie;
    mie_word[csr_pkg::irq_mei] = state.meie;
  end

  // Bit 1 of mtvec is reserved and reads as zero
  assign mtvec_word = {state.mtvec_base, 1'b0, state.mtvec_mode};

  // Selection is one-hot, so an AND-OR mux is enough
  assign rd_data = ({csr_pkg::xlen{sel.mstatus}}  & mstatus_word)
                 | ({csr_pkg::xlen{sel.misa}}     & csr_pkg::misa_value)
                 | ({csr_pkg::xlen{sel.mie}}      & mie_word)
                 | ({csr_pkg::xlen{sel.mtvec}}    & mtvec_word)
                 | ({csr_pkg::xlen{sel.mscratch}} & state.mscratch)
                 | ({csr_pkg::xlen{sel.mepc}}     & state.mepc)
                 | ({csr_pkg::xlen{sel.mcause}}   & state.mcause)
                 | ({csr_pkg::xlen{sel.mtval}}    & state.mtval)
                 | ({csr_pkg::xlen{sel.mip}}      & mip);

  // Vectored mode offsets interrupts by 4 * cause
  assign base_addr     = {state.mtvec_base, 2'b00};
  assign vector_offset = {{(csr_pkg::xlen-6){1'b0}}, trap_info.code, 2'b00};
  assign trap_addr     = (state.mtvec_mode && trap_info.interrupt) ?
                         base_addr + vector_offset : base_addr;

endmodule

`default_nettype wire

// ==== verilog/csr_machine_regs.sv ====
// ##########################################################################
// Machine CSR state and privilege mode, updated by trap entry, mret and
// committed CSR writes, plus the live mip word
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs (
  input  logic                clock,
  input  logic                reset,
  input  csr_pkg::csr_write_t wr,
  input  logic                mret_commit,
  input  csr_pkg::trap_t      trap_info,
  input  csr_pkg::xlen_t      pc,
  input  csr_pkg::instr_t     instruction,
  input  logic                external_interrupt,
  input  logic                mem_msip,
  input  csr_pkg::timer_t     mem_mtime,
  input  csr_pkg::timer_t     mem_mtimecmp,
  output csr_pkg::csr_state_t state,
  output csr_pkg::xlen_t      mip
);

  logic                     status_mie;
  logic                     status_mpie;
  csr_pkg::priv_e           status_mpp;
  csr_pkg::priv_e           priv;
  logic                     msie;
  logic                     mtie;
  logic                     meie;
  logic [csr_pkg::xlen-3:0] mtvec_base;
  logic                     mtvec_mode;
  csr_pkg::xlen_t           mscratch;
  csr_pkg::xlen_t           mepc;
  csr_pkg::xlen_t           mcause;
  csr_pkg::xlen_t           mtval;
  logic [1:0]               wr_mpp;
  logic                     mpp_legal;

  // mcause only holds the causes this core can raise
  function automatic logic cause_legal(input csr_pkg::xlen_t value);
    logic [csr_pkg::xlen-2:0] code;
    code = value[csr_pkg::xlen-2:0];
    if (value[csr_pkg::xlen-1]) begin
      cause_legal = (code == 31'(csr_pkg::irq_msi)) || (code == 31'(csr_pkg::irq_mti)) ||
                    (code == 31'(csr_pkg::irq_mei));
    end else begin
      cause_legal = (code == 31'(csr_pkg::exc_illegal)) ||
                    (code == 31'(csr_pkg::exc_ecall_u)) ||
                    (code == 31'(csr_pkg::exc_ecall_m));
    end
  endfunction

  // Only U or M are legal for mpp
  assign wr_mpp    = wr.data[csr_pkg::mstatus_mpp +: 2];
  assign mpp_legal = (wr_mpp == csr_pkg::priv_user) || (wr_mpp == csr_pkg::priv_machine);

  // mstatus and privilege
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      status_mie  <= 1'b0;
      status_mpie <= 1'b0;
      status_mpp  <= csr_pkg::priv_user;
      priv        <= csr_pkg::priv_machine;
    end else if (trap_info.trap) begin
      status_mpie <= status_mie;
      status_mie  <= 1'b0;
      status_mpp  <= priv;
      priv        <= csr_pkg::priv_machine;
    end else if (mret_commit) begin
      status_mie  <= status_mpie;
      status_mpie <= 1'b1;
      priv        <= status_mpp;
      status_mpp  <= csr_pkg::priv_user;
    end else if (wr.en.mstatus) begin
      status_mie  <= wr.data[csr_pkg::mstatus_mie];
      status_mpie <= wr.data[csr_pkg::mstatus_mpie];
      if (mpp_legal) begin
        status_mpp <= csr_pkg::priv_e'(wr_mpp);
      end
    end
  end

  // mie enables and mtvec
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      msie       <= 1'b0;
      mtie       <= 1'b0;
      meie       <= 1'b0;
      mtvec_base <= '0;
      mtvec_mode <= 1'b0;
    end else begin
      if (wr.en.mie) begin
        msie <= wr.data[csr_pkg::irq_msi];
        mtie <= wr.data[csr_pkg::irq_mti];
        meie <= wr.data[csr_pkg::irq_mei];
      end
      if (wr.en.mtvec) begin
        mtvec_base <= wr.data[csr_pkg::xlen-1:2];
        mtvec_mode <= wr.data[0];
      end
    end
  end

  // Trap record registers and mscratch
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (trap_info.trap) begin
      mepc   <= pc;
      mcause <= {trap_info.interrupt, {(csr_pkg::xlen-5){1'b0}}, trap_info.code};
      // Faulting word kept only for illegal instruction
      if (trap_info.illegal) begin
        mtval <= instruction;
      end
    end else begin
      if (wr.en.mscratch) begin
        mscratch <= wr.data;
      end
      if (wr.en.mepc) begin
        mepc <= {wr.data[csr_pkg::xlen-1:2], 2'b00};
      end
      if (wr.en.mcause && cause_legal(wr.data)) begin
        mcause <= wr.data;
      end
      if (wr.en.mtval) begin
        mtval <= wr.data;
      end
    end
  end

  // Pending bits come straight from the platform
  always_comb begin
    mip                   = '0;
    mip[csr_pkg::irq_msi] = mem_msip;
    mip[csr_pkg::irq_mti] = (mem_mtime >= mem_mtimecmp);
    mip[csr_pkg::irq_mei] = external_interrupt;
  end

  always_comb begin
    state.status_mie  = status_mie;
    state.status_mpie = status_mpie;
    state.status_mpp  = status_mpp;
    state.msie        = msie;
    state.mtie        = mtie;
    state.meie        = meie;
    state.mtvec_base  = mtvec_base;
    state.mtvec_mode  = mtvec_mode;
    state.mscratch    = mscratch;
    state.mepc        = mepc;
    state.mcause      = mcause;
    state.mtval       = mtval;
    state.priv        = priv;
  end

endmodule

`default_nettype wire

// ==== verilog/csr_trap_unit.sv ====
// ##########################################################################
// Trap arbitration: qualifies machine interrupts and exceptions, picks the
// highest priority event and forms its cause
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit (
  input  csr_pkg::csr_state_t state,
  input  csr_pkg::xlen_t      mip,
  input  logic                illegal_instruction,
  input  logic                ecall,
  output csr_pkg::trap_t      trap_info
);

  logic user_mode;
  logic global_en;
  logic mei_take;
  logic mti_take;
  logic msi_take;
  logic illegal_take;
  logic ecall_take;

  assign user_mode = (state.priv == csr_pkg::priv_user);

  // Machine traps are always open from user mode, gated by mstatus.mie
  // in machine mode
  assign global_en = user_mode | state.status_mie;

  // Interrupt needs both its pending bit and its enable bit
  assign mei_take = mip[csr_pkg::irq_mei] & state.meie & global_en;
  assign mti_take = mip[csr_pkg::irq_mti] & state.mtie & global_en;
  assign msi_take = mip[csr_pkg::irq_msi] & state.msie & global_en;

  // Exceptions follow the same privilege rule
  assign illegal_take = illegal_instruction & global_en;
  assign ecall_take   = ecall & global_en;

  // Fixed priority MEI > MTI > MSI > illegal > ecall
  always_comb begin
    trap_info = '0;
    if (mei_take) begin
      trap_info.trap      = 1'b1;
      trap_info.interrupt = 1'b1;
      trap_info.code      = 4'(csr_pkg::irq_mei);
    end else if (mti_take) begin
      trap_info.trap      = 1'b1;
      trap_info.interrupt = 1'b1;
      trap_info.code      = 4'(csr_pkg::irq_mti);
    end else if (msi_take) begin
      trap_info.trap      = 1'b1;
      trap_info.interrupt = 1'b1;
      trap_info.code      = 4'(csr_pkg::irq_msi);
    end else if (illegal_take) begin
      trap_info.trap    = 1'b1;
      trap_info.code    = csr_pkg::exc_illegal;
      trap_info.illegal = 1'b1;
    end else if (ecall_take) begin
      trap_info.trap = 1'b1;
      // Cause depends on the mode the ecall came from
      trap_info.code = user_mode ? csr_pkg::exc_ecall_u : csr_pkg::exc_ecall_m;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/csr_addr_decode.sv ====
// ##########################################################################
// CSR address decode: one-hot selection, committed write strobes, mret
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module csr_addr_decode (
  input  csr_pkg::csr_addr_t  addr,
  input  logic                wr_en,
  input  csr_pkg::xlen_t      wr_data,
  input  logic                mret,
  input  logic                trap,
  output csr_pkg::csr_sel_t   sel,
  output csr_pkg::csr_write_t wr,
  output logic                mret_commit,
  output logic                addr_exception
);

  logic wr_commit;

  always_comb begin
    sel            = '0;
    addr_exception = 1'b0;
    case (addr)
      csr_pkg::addr_mstatus:  sel.mstatus  = 1'b1;
      csr_pkg::addr_misa:     sel.misa     = 1'b1;
      csr_pkg::addr_mie:      sel.mie      = 1'b1;
      csr_pkg::addr_mtvec:    sel.mtvec    = 1'b1;
      csr_pkg::addr_mscratch: sel.mscratch = 1'b1;
      csr_pkg::addr_mepc:     sel.mepc     = 1'b1;
      csr_pkg::addr_mcause:   sel.mcause   = 1'b1;
      csr_pkg::addr_mtval:    sel.mtval    = 1'b1;
      csr_pkg::addr_mip:      sel.mip      = 1'b1;
      default:                addr_exception = 1'b1;
    endcase
  end

  // A trap wins over mret, and both win over a write
  assign mret_commit = mret & ~trap;
  assign wr_commit   = wr_en & ~mret & ~trap;

  assign wr.en   = wr_commit ? sel : '0;
  assign wr.data = wr_data;

endmodule

`default_nettype wire

// ==== verilog/csr_pkg.sv ====
// ##########################################################################
// Machine CSR unit definitions: widths, CSR addresses, field positions,
// cause codes and the structs shared by the CSR blocks
// ##########################################################################
`default_nettype none

package csr_pkg;

  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [31:0]     instr_t;
  typedef logic [63:0]     timer_t;

  // Machine CSR addresses
  localparam csr_addr_t addr_mstatus  = 12'h300;
  localparam csr_addr_t addr_misa     = 12'h301;
  localparam csr_addr_t addr_mie      = 12'h304;
  localparam csr_addr_t addr_mtvec    = 12'h305;
  localparam csr_addr_t addr_mscratch = 12'h340;
  localparam csr_addr_t addr_mepc     = 12'h341;
  localparam csr_addr_t addr_mcause   = 12'h342;
  localparam csr_addr_t addr_mtval    = 12'h343;
  localparam csr_addr_t addr_mip      = 12'h344;

  // mstatus field positions, mpp is two bits wide
  localparam int unsigned mstatus_mie  = 3;
  localparam int unsigned mstatus_mpie = 7;
  localparam int unsigned mstatus_mpp  = 11;

  // Interrupt bit positions in mip and mie, equal to their cause codes
  localparam int unsigned irq_msi = 3;
  localparam int unsigned irq_mti = 7;
  localparam int unsigned irq_mei = 11;

  // Exception cause codes
  localparam logic [3:0] exc_illegal = 4'd2;
  localparam logic [3:0] exc_ecall_u = 4'd8;
  localparam logic [3:0] exc_ecall_m = 4'd11;

  // MXL = 1 (RV32), extensions I and U
  localparam xlen_t misa_value = 32'h4010_0100;

  typedef enum logic [1:0] {
    priv_user    = 2'b00,
    priv_machine = 2'b11
  } priv_e;

  // One-hot CSR selection
  typedef struct packed {
    logic mstatus;
    logic misa;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mtval;
    logic mip;
  } csr_sel_t;

  // Committed write strobes per CSR and the write word
  typedef struct packed {
    csr_sel_t en;
    xlen_t    data;
  } csr_write_t;

  typedef struct packed {
    logic             status_mie;
    logic             status_mpie;
    priv_e            status_mpp;
    logic             msie;
    logic             mtie;
    logic             meie;
    logic [xlen-3:0]  mtvec_base;
    logic             mtvec_mode;
    xlen_t            mscratch;
    xlen_t            mepc;
    xlen_t            mcause;
    xlen_t            mtval;
    priv_e            priv;
  } csr_state_t;

  typedef struct packed {
    logic       trap;
    logic       interrupt;
    logic [3:0] code;
    // Set only for an illegal-instruction trap
    logic       illegal;
  } trap_t;

endpackage

`default_nettype wire
